/* Makefile */
# Verilator build and run for the decode stage testbench

TOP       ?= tb_id_stage
SEED      ?= 26414
LOG       ?= sim.log
VERILATOR ?= verilator
OBJ_DIR   ?= obj_dir

.PHONY: help build test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass line"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"
	@echo "Variables: TOP=$(TOP) SEED=$(SEED) LOG=$(LOG) VERILATOR=$(VERILATOR)"

build:
	$(VERILATOR) --binary --timing --assert -Mdir $(OBJ_DIR) \
		--top-module $(TOP) -GSEED=$(SEED) -f list.f

test: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "TEST PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* hw/id_ex_pipe.sv */
/*
  Operand A/B/C muxes and the single-entry ID/EX register with valid/ready
  Whole register clears on reset, so EX sees ALU_ADD and zero operands
*/
module id_ex_pipe (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            if_valid_i,
  input  id_pkg::if_id_t  if_id_i,
  input  id_pkg::decode_t dec_i,
  input  id_pkg::word_t   fwd_a_i,
  input  id_pkg::word_t   fwd_b_i,
  input  id_pkg::word_t   imm_b_i,
  input  id_pkg::word_t   bch_target_i,
  input  logic            ex_ready_i,
  output logic            id_ready_o,
  output logic            ex_valid_o,
  output id_pkg::id_ex_t  id_ex_o
);

  logic           accept;
  id_pkg::id_ex_t id_ex_d;

  ////////////////////////////////
  // Handshake
  ////////////////////////////////
  // Room when the slot is empty or drains this cycle
  assign id_ready_o = ex_ready_i || !ex_valid_o;
  assign accept     = if_valid_i && id_ready_o;

  ////////////////////////////////
  // Next stage contents
  ////////////////////////////////
  always_comb begin
    id_ex_d = '0;

    // Operand A
    case (dec_i.op_a_sel)
      id_pkg::OP_A_PC:   id_ex_d.op_a = if_id_i.pc;
      id_pkg::OP_A_ZERO: id_ex_d.op_a = '0;
      default:           id_ex_d.op_a = fwd_a_i;
    endcase

    // Operand B
    case (dec_i.op_b_sel)
      id_pkg::OP_B_IMM:    id_ex_d.op_b = imm_b_i;
      id_pkg::OP_B_PCINCR: id_ex_d.op_b = id_pkg::PC_INCR;
      default:             id_ex_d.op_b = fwd_b_i;
    endcase

    // Operand C, store data or branch target
    case (dec_i.op_c_sel)
      id_pkg::OP_C_REGB: id_ex_d.op_c = fwd_b_i;
      id_pkg::OP_C_BCH:  id_ex_d.op_c = bch_target_i;
      default:           id_ex_d.op_c = '0;
    endcase

    id_ex_d.alu_op       = dec_i.alu_op;
    id_ex_d.rf_we        = dec_i.rf_we;
    id_ex_d.rf_waddr     = if_id_i.instr[id_pkg::RD_LSB +: $bits(id_pkg::reg_addr_t)];
    id_ex_d.lsu_en       = dec_i.lsu_en;
    id_ex_d.lsu_we       = dec_i.lsu_we;
    id_ex_d.lsu_size     = dec_i.lsu_size;
    id_ex_d.lsu_sign_ext = dec_i.lsu_sign_ext;
    id_ex_d.branch       = (dec_i.xfer == id_pkg::XFER_BRANCH);
    id_ex_d.illegal      = dec_i.illegal;
    id_ex_d.pc           = if_id_i.pc;
    id_ex_d.instr        = if_id_i.instr;
  end

  ////////////////////////////////
  // ID/EX register
  ////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex_valid_o <= 1'b0;
      id_ex_o    <= '0;
    end else if (accept) begin
      ex_valid_o <= 1'b1;
      id_ex_o    <= id_ex_d;
    end else if (ex_ready_i) begin
      // Drained with nothing new, payload left as is
      ex_valid_o <= 1'b0;
    end
  end

endmodule

/* hw/id_pkg.sv */
/*
  Shared types for the RV32I decode stage. Only the base integer subset is covered
  Enum encodings with value 0 are the reset values of the ID/EX register
*/
package id_pkg;

  //////////////////////////////
  // Widths and field positions
  //////////////////////////////
  localparam int XLEN        = 32;
  localparam int NUM_REGS    = 32;
  localparam int NUM_RF_READ = 2;

  localparam int RS1_LSB = 15;
  localparam int RS2_LSB = 20;
  localparam int RD_LSB  = 7;

  // Major opcodes of the kept subset
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

  //////////////////////////////
  // Scalar types
  //////////////////////////////
  typedef logic [XLEN-1:0] word_t;
  typedef logic [31:0]     instr_t;
  typedef logic [4:0]      reg_addr_t;
  // 0 byte, 1 half, 2 word
  typedef logic [1:0]      lsu_size_t;

  // Link increment, no compressed support
  localparam word_t PC_INCR = 32'd4;

  //////////////////////////////
  // Decoder select fields
  //////////////////////////////
  // ADD first so that a cleared ID/EX register holds ADD
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA,
    ALU_OR, ALU_AND, ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  typedef enum logic [1:0] {OP_A_REG, OP_A_PC, OP_A_ZERO} op_a_sel_e;
  typedef enum logic [1:0] {OP_B_REG, OP_B_IMM, OP_B_PCINCR} op_b_sel_e;
  typedef enum logic [1:0] {IMM_I, IMM_S, IMM_U} imm_sel_e;
  typedef enum logic [1:0] {OP_C_REGB, OP_C_BCH, OP_C_ZERO} op_c_sel_e;
  typedef enum logic [1:0] {XFER_NONE, XFER_JUMP, XFER_BRANCH} xfer_e;
  typedef enum logic {JT_JAL, JT_JALR} jt_sel_e;

  //////////////////////////////
  // Bundles
  //////////////////////////////
  typedef struct packed {
    instr_t instr;
    word_t  pc;
  } if_id_t;

  // Shared by the EX forward port and the WB write port
  typedef struct packed {
    logic      we;
    reg_addr_t addr;
    word_t     data;
  } rf_wr_t;

  typedef struct packed {
    alu_op_e                alu_op;
    op_a_sel_e              op_a_sel;
    op_b_sel_e              op_b_sel;
    imm_sel_e               imm_sel;
    op_c_sel_e              op_c_sel;
    logic [NUM_RF_READ-1:0] rf_re;     // Bit 0 is rs1, bit 1 is rs2
    logic                   rf_we;
    logic                   lsu_en;
    logic                   lsu_we;
    lsu_size_t              lsu_size;
    logic                   lsu_sign_ext;
    xfer_e                  xfer;
    jt_sel_e                jt_sel;
    logic                   illegal;
  } decode_t;

  typedef struct packed {
    alu_op_e   alu_op;
    word_t     op_a;
    word_t     op_b;
    word_t     op_c;
    logic      rf_we;
    reg_addr_t rf_waddr;
    logic      lsu_en;
    logic      lsu_we;
    lsu_size_t lsu_size;
    logic      lsu_sign_ext;
    logic      branch;
    logic      illegal;
    word_t     pc;
    instr_t    instr;
  } id_ex_t;

endpackage

/* hw/id_stage.sv */
/*
  RV32I decode stage top. One instruction in flight, 1 cycle to EX
  jmp_target_o is combinational from the instruction in decode
*/
module id_stage (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           if_valid_i,
  input  id_pkg::if_id_t if_id_i,
  output logic           id_ready_o,
  input  id_pkg::rf_wr_t ex_fwd_i,
  input  id_pkg::rf_wr_t wb_wr_i,
  input  logic           ex_ready_i,
  output logic           ex_valid_o,
  output id_pkg::id_ex_t id_ex_o,
  output id_pkg::word_t  jmp_target_o
);

  id_pkg::decode_t   dec;
  id_pkg::reg_addr_t rs_addr  [id_pkg::NUM_RF_READ];
  id_pkg::word_t     rf_data  [id_pkg::NUM_RF_READ];
  id_pkg::word_t     fwd_data [id_pkg::NUM_RF_READ];
  id_pkg::word_t     imm_b;
  id_pkg::word_t     bch_target;

  instr_decoder u_decoder (
    .instr_i (if_id_i.instr),
    .dec_o   (dec)
  );

  ////////////////////////////////
  // Register read and forwarding
  ////////////////////////////////
  reg_file u_reg_file (
    .clk       (clk),
    .rst_n     (rst_n),
    .wb_wr_i   (wb_wr_i),
    .rs_addr_i (rs_addr),
    .rs_data_o (rf_data)
  );

  for (genvar g = 0; g < id_pkg::NUM_RF_READ; g++) begin : g_fwd
    localparam int RS_LSB = (g == 0) ? id_pkg::RS1_LSB : id_pkg::RS2_LSB;

    // Unused ports read x0, so they also never match a forward
    assign rs_addr[g] = dec.rf_re[g] ? if_id_i.instr[RS_LSB +: $bits(id_pkg::reg_addr_t)]
                                     : '0;

    operand_fwd u_operand_fwd (
      .rs_addr_i (rs_addr[g]),
      .rf_data_i (rf_data[g]),
      .ex_fwd_i  (ex_fwd_i),
      .wb_wr_i   (wb_wr_i),
      .operand_o (fwd_data[g])
    );
  end

  // Port 0 doubles as the JALR base
  imm_target_gen u_imm_target_gen (
    .instr_i      (if_id_i.instr),
    .pc_i         (if_id_i.pc),
    .imm_sel_i    (dec.imm_sel),
    .jt_sel_i     (dec.jt_sel),
    .jalr_base_i  (fwd_data[0]),
    .imm_b_o      (imm_b),
    .bch_target_o (bch_target),
    .jmp_target_o (jmp_target_o)
  );

  id_ex_pipe u_id_ex_pipe (
    .clk          (clk),
    .rst_n        (rst_n),
    .if_valid_i   (if_valid_i),
    .if_id_i      (if_id_i),
    .dec_i        (dec),
    .fwd_a_i      (fwd_data[0]),
    .fwd_b_i      (fwd_data[1]),
    .imm_b_i      (imm_b),
    .bch_target_i (bch_target),
    .ex_ready_i   (ex_ready_i),
    .id_ready_o   (id_ready_o),
    .ex_valid_o   (ex_valid_o),
    .id_ex_o      (id_ex_o)
  );

endmodule

/* hw/imm_target_gen.sv */
/*
  Immediate extraction and PC target adders, all combinational
  The JALR base must already be forwarded by the caller
*/
module imm_target_gen (
  input  id_pkg::instr_t   instr_i,
  input  id_pkg::word_t    pc_i,
  input  id_pkg::imm_sel_e imm_sel_i,
  input  id_pkg::jt_sel_e  jt_sel_i,
  input  id_pkg::word_t    jalr_base_i,
  output id_pkg::word_t    imm_b_o,
  output id_pkg::word_t    bch_target_o,
  output id_pkg::word_t    jmp_target_o
);

  id_pkg::word_t imm_i;
  id_pkg::word_t imm_s;
  id_pkg::word_t imm_sb;
  id_pkg::word_t imm_u;
  id_pkg::word_t imm_uj;
  id_pkg::word_t jalr_sum;

  // Sign bit is always instr[31]
  assign imm_i  = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s  = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_sb = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                   instr_i[11:8], 1'b0};
  assign imm_u  = {instr_i[31:12], 12'b0};
  assign imm_uj = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                   instr_i[30:21], 1'b0};

  // Operand B immediate
  always_comb begin
    case (imm_sel_i)
      id_pkg::IMM_S: imm_b_o = imm_s;
      id_pkg::IMM_U: imm_b_o = imm_u;
      default:       imm_b_o = imm_i;
    endcase
  end

  ////////////////////////////////
  // Targets
  ////////////////////////////////
  assign bch_target_o = pc_i + imm_sb;
  assign jalr_sum     = jalr_base_i + imm_i;

  // JALR clears bit 0 of the sum
  assign jmp_target_o = (jt_sel_i == id_pkg::JT_JALR) ? {jalr_sum[31:1], 1'b0}
                                                      : pc_i + imm_uj;

endmodule

/* hw/instr_decoder.sv */
/*
  Combinational RV32I base decoder. No M, A, C, CSR or system instructions
  Anything outside the subset is flagged illegal with every enable low
*/
module instr_decoder (
  input  id_pkg::instr_t  instr_i,
  output id_pkg::decode_t dec_o
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       illegal;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  // Shared funct3 map of OP and OP-IMM, alt picks SUB or SRA
  function automatic id_pkg::alu_op_e alu_op_f3(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? id_pkg::ALU_SUB : id_pkg::ALU_ADD;
      3'b001:  return id_pkg::ALU_SLL;
      3'b010:  return id_pkg::ALU_SLT;
      3'b011:  return id_pkg::ALU_SLTU;
      3'b100:  return id_pkg::ALU_XOR;
      3'b101:  return alt ? id_pkg::ALU_SRA : id_pkg::ALU_SRL;
      3'b110:  return id_pkg::ALU_OR;
      default: return id_pkg::ALU_AND;
    endcase
  endfunction

  always_comb begin
    illegal         = 1'b0;
    dec_o           = '0;
    dec_o.op_c_sel  = id_pkg::OP_C_ZERO;

    case (opcode)
      id_pkg::OPC_OP: begin
        dec_o.rf_re  = 2'b11;
        dec_o.rf_we  = 1'b1;
        dec_o.alu_op = alu_op_f3(funct3, funct7[5]);
        // Alternate encoding only exists for SUB and SRA
        if (funct7 == 7'h20) begin
          illegal = (funct3 != 3'b000) && (funct3 != 3'b101);
        end else begin
          illegal = (funct7 != 7'h00);
        end
      end

      id_pkg::OPC_OP_IMM: begin
        dec_o.rf_re    = 2'b01;
        dec_o.rf_we    = 1'b1;
        dec_o.op_b_sel = id_pkg::OP_B_IMM;
        dec_o.imm_sel  = id_pkg::IMM_I;
        // Upper immediate bits only carry meaning for the shifts
        dec_o.alu_op   = alu_op_f3(funct3, (funct3 == 3'b101) && funct7[5]);
        if (funct3 == 3'b001) begin
          illegal = (funct7 != 7'h00);
        end else if (funct3 == 3'b101) begin
          illegal = (funct7 != 7'h00) && (funct7 != 7'h20);
        end
      end

      id_pkg::OPC_LOAD: begin
        dec_o.rf_re        = 2'b01;
        dec_o.rf_we        = 1'b1;
        dec_o.op_b_sel     = id_pkg::OP_B_IMM;
        dec_o.imm_sel      = id_pkg::IMM_I;
        dec_o.lsu_en       = 1'b1;
        dec_o.lsu_size     = funct3[1:0];
        dec_o.lsu_sign_ext = !funct3[2];
        // LB LH LW LBU LHU only
        illegal = (funct3[1:0] == 2'b11) || (funct3[2] && funct3[1]);
      end

      id_pkg::OPC_STORE: begin
        dec_o.rf_re    = 2'b11;
        dec_o.op_b_sel = id_pkg::OP_B_IMM;
        dec_o.imm_sel  = id_pkg::IMM_S;
        dec_o.op_c_sel = id_pkg::OP_C_REGB;  // Store data travels on operand C
        dec_o.lsu_en   = 1'b1;
        dec_o.lsu_we   = 1'b1;
        dec_o.lsu_size = funct3[1:0];
        illegal = funct3[2] || (funct3[1:0] == 2'b11);
      end

      id_pkg::OPC_BRANCH: begin
        dec_o.rf_re    = 2'b11;
        dec_o.op_c_sel = id_pkg::OP_C_BCH;
        dec_o.xfer     = id_pkg::XFER_BRANCH;
        case (funct3)
          3'b000:  dec_o.alu_op = id_pkg::ALU_EQ;
          3'b001:  dec_o.alu_op = id_pkg::ALU_NE;
          3'b100:  dec_o.alu_op = id_pkg::ALU_LT;
          3'b101:  dec_o.alu_op = id_pkg::ALU_GE;
          3'b110:  dec_o.alu_op = id_pkg::ALU_LTU;
          3'b111:  dec_o.alu_op = id_pkg::ALU_GEU;
          default: illegal = 1'b1;
        endcase
      end

      id_pkg::OPC_JAL, id_pkg::OPC_JALR: begin
        // Link value is PC plus 4 computed by the ALU
        dec_o.rf_we    = 1'b1;
        dec_o.op_a_sel = id_pkg::OP_A_PC;
        dec_o.op_b_sel = id_pkg::OP_B_PCINCR;
        dec_o.xfer     = id_pkg::XFER_JUMP;
        if (opcode == id_pkg::OPC_JALR) begin
          dec_o.rf_re  = 2'b01;
          dec_o.jt_sel = id_pkg::JT_JALR;
          illegal      = (funct3 != 3'b000);
        end
      end

      id_pkg::OPC_LUI, id_pkg::OPC_AUIPC: begin
        dec_o.rf_we    = 1'b1;
        dec_o.op_a_sel = (opcode == id_pkg::OPC_LUI) ? id_pkg::OP_A_ZERO : id_pkg::OP_A_PC;
        dec_o.op_b_sel = id_pkg::OP_B_IMM;
        dec_o.imm_sel  = id_pkg::IMM_U;
      end

      default: illegal = 1'b1;
    endcase

    // Squash everything but the flag
    if (illegal) begin
      dec_o         = '0;
      dec_o.illegal = 1'b1;
    end
  end

endmodule

/* hw/operand_fwd.sv */
/*
  Forward mux for one source register. EX beats WB, WB beats the file
  A source of x0 never takes a forward
*/
module operand_fwd (
  input  id_pkg::reg_addr_t rs_addr_i,
  input  id_pkg::word_t     rf_data_i,
  input  id_pkg::rf_wr_t    ex_fwd_i,
  input  id_pkg::rf_wr_t    wb_wr_i,
  output id_pkg::word_t     operand_o
);

  logic rs_nz;
  logic hit_ex;
  logic hit_wb;

  assign rs_nz  = (rs_addr_i != '0);
  assign hit_ex = rs_nz && ex_fwd_i.we && (ex_fwd_i.addr == rs_addr_i);
  assign hit_wb = rs_nz && wb_wr_i.we && (wb_wr_i.addr == rs_addr_i);

  // Newest result first
  assign operand_o = hit_ex ? ex_fwd_i.data :
                     hit_wb ? wb_wr_i.data  : rf_data_i;

endmodule

/* hw/reg_file.sv */
/*
  32 x 32 register file, combinational reads, write on the rising edge
  x0 has no storage and always reads zero
*/
module reg_file (
  input  logic              clk,
  input  logic              rst_n,
  input  id_pkg::rf_wr_t    wb_wr_i,
  input  id_pkg::reg_addr_t rs_addr_i [id_pkg::NUM_RF_READ],
  output id_pkg::word_t     rs_data_o [id_pkg::NUM_RF_READ]
);

  // Storage for x1 to x31
  id_pkg::word_t regs [1:id_pkg::NUM_REGS-1];

  // Write port from WB
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < id_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_wr_i.we && (wb_wr_i.addr != '0)) begin
      regs[wb_wr_i.addr] <= wb_wr_i.data;
    end
  end

  // Read ports, no internal bypass
  always_comb begin
    for (int p = 0; p < id_pkg::NUM_RF_READ; p++) begin
      rs_data_o[p] = (rs_addr_i[p] == '0) ? '0 : regs[rs_addr_i[p]];
    end
  end

endmodule

/* list.f */
hw/id_pkg.sv
hw/instr_decoder.sv
hw/imm_target_gen.sv
hw/reg_file.sv
hw/operand_fwd.sv
hw/id_ex_pipe.sv
hw/id_stage.sv
testbench/tb_id_stage.sv

/* testbench/tb_id_stage.sv */
/*
  Testbench for the decode stage. Expected values come from a register mirror and the ISA rules
  Stimulus covers legal RV32I encodings plus one unknown opcode
*/
module tb_id_stage #(
  parameter int SEED = 26414
);
  timeunit 1ns;
  timeprecision 100ps;

  // Cycle budget of each test and a run limit of twice their sum
  localparam int LEN_TOTAL = 20 + 80 + 30 + 40 + 40 + 30;
  localparam int CYCLE_LIMIT = 2 * LEN_TOTAL;

  logic clk = 1'b0;
  logic rst_n;
  logic if_valid;
  id_pkg::if_id_t if_id;
  id_pkg::rf_wr_t ex_fwd;
  id_pkg::rf_wr_t wb_wr;
  logic ex_ready;
  logic id_ready_o;
  logic ex_valid_o;
  id_pkg::id_ex_t id_ex_o;
  id_pkg::word_t jmp_target_o;

  id_pkg::word_t mirror [id_pkg::NUM_REGS];
  id_pkg::id_ex_t exp_q;
  id_pkg::id_ex_t exp_next;
  id_pkg::word_t exp_jt;
  id_pkg::rf_wr_t pend_wb;
  logic chk;
  logic chk_jt;
  int errors;
  int cycles = 0;
  id_pkg::word_t pc;

  id_stage UUT (
    .clk(clk), .rst_n(rst_n), .if_valid_i(if_valid), .if_id_i(if_id),
    .id_ready_o(id_ready_o), .ex_fwd_i(ex_fwd), .wb_wr_i(wb_wr), .ex_ready_i(ex_ready),
    .ex_valid_o(ex_valid_o), .id_ex_o(id_ex_o), .jmp_target_o(jmp_target_o)
  );

  always #10 clk = ~clk;

  // Run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: run passed %0d cycles without finishing", CYCLE_LIMIT);
      $display("TEST FAIL");
      $finish;
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////
  assert property (@(posedge clk) chk |-> id_ex_o == exp_q)
    else begin
      $display("mismatch id_ex_o exp=%h got=%h", $sampled(exp_q), $sampled(id_ex_o));
      errors++;
    end

  assert property (@(posedge clk) chk |-> ex_valid_o)
    else begin
      $display("ex_valid_o low one cycle after an accepted instruction");
      errors++;
    end

  assert property (@(posedge clk) chk_jt |-> jmp_target_o == exp_jt)
    else begin
      $display("mismatch jmp_target_o exp=%h got=%h", $sampled(exp_jt), $sampled(jmp_target_o));
      errors++;
    end

  // Stall holds the slot and blocks fetch
  assert property (@(posedge clk) (rst_n && ex_valid_o && !ex_ready) |-> !id_ready_o)
    else begin
      $display("id_ready_o high while EX stalls a valid instruction");
      errors++;
    end

  assert property (@(posedge clk) (rst_n && ex_valid_o && !ex_ready)
                   |=> ($stable(id_ex_o) && ex_valid_o))
    else begin
      $display("id_ex_o or ex_valid_o changed during a stall");
      errors++;
    end

  //////////////////////////////
  // Encoders
  //////////////////////////////
  function automatic id_pkg::instr_t enc_r(logic [6:0] f7, id_pkg::reg_addr_t rs2,
      id_pkg::reg_addr_t rs1, logic [2:0] f3, id_pkg::reg_addr_t rd, logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic id_pkg::instr_t enc_s(logic [11:0] imm, id_pkg::reg_addr_t rs2,
      id_pkg::reg_addr_t rs1, logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], id_pkg::OPC_STORE};
  endfunction

  function automatic id_pkg::instr_t enc_b(logic [12:0] imm, id_pkg::reg_addr_t rs2,
      id_pkg::reg_addr_t rs1, logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], id_pkg::OPC_BRANCH};
  endfunction

  function automatic id_pkg::instr_t enc_j(logic [20:0] imm, id_pkg::reg_addr_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, id_pkg::OPC_JAL};
  endfunction

  function automatic id_pkg::rf_wr_t mk_wr(logic we, id_pkg::reg_addr_t a, id_pkg::word_t d);
    id_pkg::rf_wr_t w;
    w.we = we;
    w.addr = a;
    w.data = d;
    return w;
  endfunction

  //////////////////////////////
  // Reference model
  //////////////////////////////
  // Newest value of a source register as seen in decode
  function automatic id_pkg::word_t src_val(id_pkg::reg_addr_t a, id_pkg::rf_wr_t ex,
      id_pkg::rf_wr_t wb);
    if (a == 0) return '0;
    if (ex.we && ex.addr == a) return ex.data;
    if (wb.we && wb.addr == a) return wb.data;
    return mirror[a];
  endfunction

  function automatic id_pkg::alu_op_e alu_from_funct3(logic [2:0] f3, logic alt);
    case (f3)
      3'd0: return alt ? id_pkg::ALU_SUB : id_pkg::ALU_ADD;
      3'd1: return id_pkg::ALU_SLL;
      3'd2: return id_pkg::ALU_SLT;
      3'd3: return id_pkg::ALU_SLTU;
      3'd4: return id_pkg::ALU_XOR;
      3'd5: return alt ? id_pkg::ALU_SRA : id_pkg::ALU_SRL;
      3'd6: return id_pkg::ALU_OR;
      default: return id_pkg::ALU_AND;
    endcase
  endfunction

  function automatic id_pkg::id_ex_t model(id_pkg::instr_t in, id_pkg::word_t p,
      id_pkg::rf_wr_t ex, id_pkg::rf_wr_t wb, output id_pkg::word_t jt);
    id_pkg::id_ex_t e;
    id_pkg::word_t rs1v;
    id_pkg::word_t rs2v;
    id_pkg::word_t imm_i;
    id_pkg::word_t imm_s;
    id_pkg::word_t imm_b;
    id_pkg::word_t imm_j;
    logic [2:0] f3;
    f3 = in[14:12];
    rs1v = src_val(in[19:15], ex, wb);
    rs2v = src_val(in[24:20], ex, wb);
    imm_i = {{20{in[31]}}, in[31:20]};
    imm_s = {{20{in[31]}}, in[31:25], in[11:7]};
    imm_b = {{20{in[31]}}, in[7], in[30:25], in[11:8], 1'b0};
    imm_j = {{12{in[31]}}, in[19:12], in[20], in[30:21], 1'b0};
    e = '0;
    e.pc = p;
    e.instr = in;
    e.rf_waddr = in[11:7];
    jt = p + imm_j;
    case (in[6:0])
      id_pkg::OPC_OP: begin
        e.op_a = rs1v;
        e.op_b = rs2v;
        e.rf_we = 1'b1;
        e.alu_op = alu_from_funct3(f3, in[30]);
      end
      id_pkg::OPC_OP_IMM: begin
        e.op_a = rs1v;
        e.op_b = imm_i;
        e.rf_we = 1'b1;
        e.alu_op = alu_from_funct3(f3, f3 == 3'd5 && in[30]);
      end
      id_pkg::OPC_LOAD: begin
        e.op_a = rs1v;
        e.op_b = imm_i;
        e.rf_we = 1'b1;
        e.lsu_en = 1'b1;
        e.lsu_size = f3[1:0];
        e.lsu_sign_ext = !f3[2];
      end
      id_pkg::OPC_STORE: begin
        e.op_a = rs1v;
        e.op_b = imm_s;
        e.op_c = rs2v;
        e.lsu_en = 1'b1;
        e.lsu_we = 1'b1;
        e.lsu_size = f3[1:0];
      end
      id_pkg::OPC_BRANCH: begin
        e.op_a = rs1v;
        e.op_b = rs2v;
        e.op_c = p + imm_b;
        e.branch = 1'b1;
        case (f3)
          3'd0: e.alu_op = id_pkg::ALU_EQ;
          3'd1: e.alu_op = id_pkg::ALU_NE;
          3'd4: e.alu_op = id_pkg::ALU_LT;
          3'd5: e.alu_op = id_pkg::ALU_GE;
          3'd6: e.alu_op = id_pkg::ALU_LTU;
          default: e.alu_op = id_pkg::ALU_GEU;
        endcase
      end
      id_pkg::OPC_JAL, id_pkg::OPC_JALR: begin
        e.op_a = p;
        e.op_b = 32'd4;
        e.rf_we = 1'b1;
        // JALR target has bit 0 cleared
        if (in[6:0] == id_pkg::OPC_JALR) jt = (rs1v + imm_i) & ~32'd1;
      end
      id_pkg::OPC_LUI: begin
        e.op_b = {in[31:12], 12'd0};
        e.rf_we = 1'b1;
      end
      id_pkg::OPC_AUIPC: begin
        e.op_a = p;
        e.op_b = {in[31:12], 12'd0};
        e.rf_we = 1'b1;
      end
      default: e.illegal = 1'b1;
    endcase
    return e;
  endfunction

  //////////////////////////////
  // Stimulus tasks
  //////////////////////////////
  task automatic wb_write(id_pkg::reg_addr_t a, id_pkg::word_t d);
    wb_wr = mk_wr(1'b1, a, d);
    @(posedge clk);
    if (a != 0) mirror[a] = d;
    #1 wb_wr = '0;
  endtask

  // Put one instruction on the fetch side and work out its expected result
  task automatic present(id_pkg::instr_t in, id_pkg::rf_wr_t ex, id_pkg::rf_wr_t wb);
    id_pkg::word_t jt;
    if_valid = 1'b1;
    if_id.instr = in;
    if_id.pc = pc;
    ex_fwd = ex;
    wb_wr = wb;
    pend_wb = wb;
    exp_next = model(in, pc, ex, wb, jt);
    exp_jt = jt;
    chk_jt = (in[6:0] == id_pkg::OPC_JAL) || (in[6:0] == id_pkg::OPC_JALR);
    pc = pc + 32'd4;
  endtask

  // Wait for the handshake, then arm the check for the following edge
  task automatic complete();
    while (!id_ready_o) begin
      @(posedge clk);
      #1;
    end
    @(posedge clk);
    if (pend_wb.we && pend_wb.addr != 0) mirror[pend_wb.addr] = pend_wb.data;
    #1;
    if_valid = 1'b0;
    ex_fwd = '0;
    wb_wr = '0;
    chk_jt = 1'b0;
    exp_q = exp_next;
    chk = 1'b1;
    @(posedge clk);
    #1 chk = 1'b0;
  endtask

  task automatic issue(id_pkg::instr_t in, id_pkg::rf_wr_t ex, id_pkg::rf_wr_t wb);
    present(in, ex, wb);
    complete();
  endtask

  task automatic end_test(string name, int errs_before);
    $display("test %-12s done, %0d errors", name, errors - errs_before);
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////
  initial begin
    int e0;
    void'($urandom(SEED));
    rst_n = 1'b0;
    if_valid = 1'b0;
    if_id = '0;
    ex_fwd = '0;
    wb_wr = '0;
    ex_ready = 1'b1;
    chk = 1'b0;
    chk_jt = 1'b0;
    exp_q = '0;
    exp_next = '0;
    exp_jt = '0;
    pend_wb = '0;
    errors = 0;
    pc = 32'h0000_1000;
    for (int i = 0; i < id_pkg::NUM_REGS; i++) mirror[i] = '0;

    // Reset
    e0 = errors;
    repeat (5) @(posedge clk);
    #1 rst_n = 1'b1;
    assert (!ex_valid_o && id_ready_o && id_ex_o == '0)
      else begin
        $display("stage not empty after reset");
        errors++;
      end
    issue(enc_r(7'h00, 5'd4, 5'd3, 3'd0, 5'd5, id_pkg::OPC_OP), '0, '0);
    end_test("reset", e0);

    // ALU register and immediate forms
    e0 = errors;
    for (int i = 1; i < 8; i++) wb_write(5'(i), $urandom);
    wb_write(5'd0, $urandom);
    for (int f = 0; f < 10; f++) begin
      issue(enc_r((f > 7) ? 7'h20 : 7'h00, 5'($urandom_range(0, 7)), 5'($urandom_range(0, 7)),
                  (f == 9) ? 3'd5 : 3'(f), 5'($urandom_range(1, 31)), id_pkg::OPC_OP), '0, '0);
    end
    for (int f = 0; f < 9; f++) begin
      logic [11:0] imm;
      imm = 12'($urandom);
      if (f == 1 || f == 5) imm[11:5] = 7'h00;
      if (f == 8) imm[11:5] = 7'h20;
      issue(enc_r(imm[11:5], imm[4:0], 5'($urandom_range(0, 7)), (f == 8) ? 3'd5 : 3'(f),
                  5'($urandom_range(1, 31)), id_pkg::OPC_OP_IMM), '0, '0);
    end
    issue(enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd9, id_pkg::OPC_OP), '0, '0);
    end_test("alu", e0);

    // Forward priority
    e0 = errors;
    wb_write(5'd6, $urandom);
    issue(enc_r(7'h00, 5'd6, 5'd6, 3'd0, 5'd7, id_pkg::OPC_OP),
          mk_wr(1'b1, 5'd6, $urandom), mk_wr(1'b1, 5'd6, $urandom));
    issue(enc_r(7'h00, 5'd6, 5'd6, 3'd4, 5'd7, id_pkg::OPC_OP), '0, mk_wr(1'b1, 5'd6, $urandom));
    issue(enc_r(7'h00, 5'd6, 5'd0, 3'd6, 5'd7, id_pkg::OPC_OP),
          mk_wr(1'b1, 5'd0, $urandom), mk_wr(1'b1, 5'd0, $urandom));
    issue(enc_r(7'h00, 5'd6, 5'd6, 3'd7, 5'd7, id_pkg::OPC_OP), '0, '0);
    end_test("forwarding", e0);

    // Loads, stores, upper immediates
    e0 = errors;
    for (int k = 0; k < 6; k++) begin
      if (k != 3) begin
        issue({12'($urandom), 5'($urandom_range(0, 7)), 3'(k), 5'($urandom_range(1, 31)),
               id_pkg::OPC_LOAD}, '0, '0);
      end
    end
    for (int k = 0; k < 3; k++) begin
      issue(enc_s(12'($urandom), 5'($urandom_range(0, 7)), 5'($urandom_range(0, 7)), 3'(k)),
            '0, '0);
    end
    issue({20'($urandom), 5'd10, id_pkg::OPC_LUI}, '0, '0);
    issue({20'($urandom), 5'd11, id_pkg::OPC_AUIPC}, '0, '0);
    end_test("memory", e0);

    // Jumps and branches
    e0 = errors;
    issue(enc_j(21'($urandom) & ~21'd1, 5'd1), '0, '0);
    issue({12'($urandom), 5'd3, 3'd0, 5'd1, id_pkg::OPC_JALR}, '0, '0);
    issue({12'($urandom), 5'd3, 3'd0, 5'd1, id_pkg::OPC_JALR}, mk_wr(1'b1, 5'd3, $urandom), '0);
    for (int k = 0; k < 8; k++) begin
      if (k != 2 && k != 3) begin
        issue(enc_b(13'($urandom) & ~13'd1, 5'($urandom_range(0, 7)),
                    5'($urandom_range(0, 7)), 3'(k)), '0, '0);
      end
    end
    end_test("transfer", e0);

    // Stall from EX, then an unknown opcode
    e0 = errors;
    ex_ready = 1'b0;
    issue(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd12, id_pkg::OPC_OP), '0, '0);
    present(enc_r(7'h00, 5'd4, 5'd3, 3'd7, 5'd13, id_pkg::OPC_OP), '0, '0);
    repeat (4) @(posedge clk);
    #1 ex_ready = 1'b1;
    complete();
    issue({25'($urandom), 7'b1111011}, '0, '0);
    end_test("stall", e0);

    $display("tests 6, errors %0d, cycles %0d", errors, cycles);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule
